//--- Bender.yml
package:
  name: rv32i_mini

sources:
  - files:
      - src/rv_pkg.sv
      - src/rv_decoder.sv
      - src/rv_execute.sv
      - src/rv_regfile.sv
      - src/rv_core.sv
      - src/mem_arbiter.sv
      - src/unified_mem.sv
      - src/rv_top.sv
  - target: test
    files:
      - tests/rv_checker.sv
      - tests/tb_rv_top.sv

//--- filelist.f
src/rv_pkg.sv
src/rv_decoder.sv
src/rv_execute.sv
src/rv_regfile.sv
src/rv_core.sv
src/mem_arbiter.sv
src/unified_mem.sv
src/rv_top.sv
tests/rv_checker.sv
tests/tb_rv_top.sv

//--- src/mem_arbiter.sv
module mem_arbiter import rv_pkg::*; (
    input  mem_req_t core_req_i,
    input  mem_req_t host_req_i,
    output mem_req_t mem_req_o,
    output logic     host_gnt_o
);

    // fixed priority, core first
    // a host request that loses is dropped and must be retried
    always_comb begin
        if (core_req_i.req) begin
            mem_req_o  = core_req_i;
            host_gnt_o = 1'b0;
        end else begin
            mem_req_o  = host_req_i;
            host_gnt_o = host_req_i.req;
        end
    end

endmodule

//--- src/rv_core.sv
module rv_core import rv_pkg::*; #(
    parameter word_t EXIT_PC = 32'h0000_0040
) (
    input  logic     clk,
    input  logic     rst_n,
    output word_t    i_addr_o,
    input  rv_inst_u inst_i,
    output mem_req_t d_req_o,
    input  word_t    d_rdata_i,
    output logic     exit_o
);

    word_t pc_q;
    ctrl_t ctrl;
    word_t imm_i;
    word_t imm_s;
    word_t rs1_data;
    word_t rs2_data;
    word_t alu_out;
    word_t wb_data;

    assign i_addr_o = pc_q;
    assign exit_o   = (pc_q == EXIT_PC); // pc freezes here, so exit holds

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= '0;
        end else if (!exit_o) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    rv_decoder u_decoder (
        .inst_i  (inst_i),
        .ctrl_o  (ctrl),
        .imm_i_o (imm_i),
        .imm_s_o (imm_s)
    );

    rv_regfile u_regfile (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1_addr_i (inst_i.r.rs1),
        .rs2_addr_i (inst_i.r.rs2),
        .rd_addr_i  (inst_i.r.rd),
        .rd_we_i    (ctrl.rf_wen && !exit_o),
        .rd_data_i  (wb_data),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    rv_execute u_execute (
        .ctrl_i     (ctrl),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .imm_i_i    (imm_i),
        .imm_s_i    (imm_s),
        .alu_out_o  (alu_out)
    );

    assign wb_data = (ctrl.wb_sel == WB_MEM) ? d_rdata_i : alu_out;

    // the data port stays free during reset so the host can preload memory
    always_comb begin
        d_req_o.req   = rst_n && !exit_o && (ctrl.mem_wen || ctrl.mem_ren);
        d_req_o.we    = ctrl.mem_wen;
        d_req_o.addr  = alu_out;
        d_req_o.wdata = rs2_data;
    end

endmodule

//--- src/rv_decoder.sv
module rv_decoder import rv_pkg::*; (
    input  rv_inst_u inst_i,
    output ctrl_t    ctrl_o,
    output word_t    imm_i_o,
    output word_t    imm_s_o
);

    // unknown encodings retire as a no-op
    localparam ctrl_t CTRL_NOP = '{
        alu_op:  ALU_ADD,
        op2_sel: OP2_RS2,
        mem_wen: 1'b0,
        mem_ren: 1'b0,
        rf_wen:  1'b0,
        wb_sel:  WB_ALU
    };

    function automatic ctrl_t alu_ctrl(alu_op_e op, op2_sel_e sel);
        ctrl_t c;
        c         = CTRL_NOP;
        c.alu_op  = op;
        c.op2_sel = sel;
        c.rf_wen  = 1'b1;
        return c;
    endfunction

    always_comb begin
        ctrl_o = CTRL_NOP;
        case (inst_i.r.opcode)
            OPC_LOAD: begin
                if (inst_i.i.funct3 == F3_LW) begin
                    ctrl_o         = alu_ctrl(ALU_ADD, OP2_IMI);
                    ctrl_o.mem_ren = 1'b1;
                    ctrl_o.wb_sel  = WB_MEM;
                end
            end
            OPC_STORE: begin
                if (inst_i.s.funct3 == F3_SW) begin
                    ctrl_o         = alu_ctrl(ALU_ADD, OP2_IMS);
                    ctrl_o.rf_wen  = 1'b0; // address calc only
                    ctrl_o.mem_wen = 1'b1;
                end
            end
            OPC_OP: begin
                if (inst_i.r.funct7 == F7_ADD) begin
                    case (inst_i.r.funct3)
                        F3_ADD:  ctrl_o = alu_ctrl(ALU_ADD, OP2_RS2);
                        F3_XOR:  ctrl_o = alu_ctrl(ALU_XOR, OP2_RS2);
                        F3_OR:   ctrl_o = alu_ctrl(ALU_OR, OP2_RS2);
                        F3_AND:  ctrl_o = alu_ctrl(ALU_AND, OP2_RS2);
                        default: ctrl_o = CTRL_NOP;
                    endcase
                end else if (inst_i.r.funct7 == F7_SUB && inst_i.r.funct3 == F3_ADD) begin
                    ctrl_o = alu_ctrl(ALU_SUB, OP2_RS2);
                end
            end
            OPC_OP_IMM: begin
                case (inst_i.i.funct3)
                    F3_ADD:  ctrl_o = alu_ctrl(ALU_ADD, OP2_IMI);
                    F3_XOR:  ctrl_o = alu_ctrl(ALU_XOR, OP2_IMI);
                    F3_OR:   ctrl_o = alu_ctrl(ALU_OR, OP2_IMI);
                    F3_AND:  ctrl_o = alu_ctrl(ALU_AND, OP2_IMI);
                    default: ctrl_o = CTRL_NOP;
                endcase
            end
            default: ctrl_o = CTRL_NOP;
        endcase
    end

    assign imm_i_o = {{(XLEN-12){inst_i.i.imm[11]}}, inst_i.i.imm};
    // store offset is split around rs1/rs2
    assign imm_s_o = {{(XLEN-12){inst_i.s.imm_hi[6]}}, inst_i.s.imm_hi, inst_i.s.imm_lo};

endmodule

//--- src/rv_execute.sv
module rv_execute import rv_pkg::*; (
    input  ctrl_t ctrl_i,
    input  word_t rs1_data_i,
    input  word_t rs2_data_i,
    input  word_t imm_i_i,
    input  word_t imm_s_i,
    output word_t alu_out_o
);

    word_t op2;

    always_comb begin
        case (ctrl_i.op2_sel)
            OP2_IMI: op2 = imm_i_i;
            OP2_IMS: op2 = imm_s_i;
            default: op2 = rs2_data_i;
        endcase
    end

    // op1 is always rs1 in this subset
    always_comb begin
        case (ctrl_i.alu_op)
            ALU_ADD: alu_out_o = rs1_data_i + op2;
            ALU_SUB: alu_out_o = rs1_data_i - op2;
            ALU_AND: alu_out_o = rs1_data_i & op2;
            ALU_OR:  alu_out_o = rs1_data_i | op2;
            ALU_XOR: alu_out_o = rs1_data_i ^ op2;
            default: alu_out_o = '0;
        endcase
    end

endmodule

//--- src/rv_pkg.sv
package rv_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    // base opcodes
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    localparam logic [2:0] F3_ADD = 3'b000; // add, sub, addi
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_SW  = 3'b010;

    localparam logic [6:0] F7_ADD = 7'b0000000;
    localparam logic [6:0] F7_SUB = 7'b0100000;

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } inst_i_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } inst_s_t;

    // same instruction word, three field layouts
    typedef union packed {
        inst_r_t r;
        inst_i_t i;
        inst_s_t s;
    } rv_inst_u;

    typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR} alu_op_e;
    typedef enum logic [1:0] {OP2_RS2, OP2_IMI, OP2_IMS} op2_sel_e;
    typedef enum logic {WB_ALU, WB_MEM} wb_sel_e;

    typedef struct packed {
        alu_op_e  alu_op;
        op2_sel_e op2_sel;
        logic     mem_wen;
        logic     mem_ren;
        logic     rf_wen;
        wb_sel_e  wb_sel;
    } ctrl_t;

    typedef struct packed {
        logic  req;
        logic  we;
        word_t addr;
        word_t wdata;
    } mem_req_t;

endpackage

//--- src/rv_regfile.sv
module rv_regfile import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t rs1_addr_i,
    input  reg_addr_t rs2_addr_i,
    input  reg_addr_t rd_addr_i,
    input  logic      rd_we_i,
    input  word_t     rd_data_i,
    output word_t     rs1_data_o,
    output word_t     rs2_data_o
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int k = 0; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (rd_we_i && rd_addr_i != '0) begin // x0 stays zero
            regs[rd_addr_i] <= rd_data_i;
        end
    end

    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

//--- src/rv_top.sv
module rv_top import rv_pkg::*; #(
    parameter word_t EXIT_PC   = 32'h0000_0040,
    parameter int    MEM_WORDS = 256
) (
    input  logic     clk,
    input  logic     rst_n,
    input  mem_req_t host_req_i,
    output logic     host_gnt_o,
    output word_t    host_rdata_o,
    output logic     exit_o
);

    word_t    i_addr;
    word_t    inst;
    word_t    rdata;
    mem_req_t core_req;
    mem_req_t mem_req;

    rv_core #(
        .EXIT_PC (EXIT_PC)
    ) u_core (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_addr_o  (i_addr),
        .inst_i    (inst),
        .d_req_o   (core_req),
        .d_rdata_i (rdata),
        .exit_o    (exit_o)
    );

    mem_arbiter u_arbiter (
        .core_req_i (core_req),
        .host_req_i (host_req_i),
        .mem_req_o  (mem_req),
        .host_gnt_o (host_gnt_o)
    );

    unified_mem #(
        .MEM_WORDS (MEM_WORDS)
    ) u_mem (
        .clk       (clk),
        .i_addr_i  (i_addr),
        .inst_o    (inst),
        .d_req_i   (mem_req),
        .d_rdata_o (rdata)
    );

    assign host_rdata_o = rdata; // shared read bus

endmodule

//--- src/unified_mem.sv
module unified_mem import rv_pkg::*; #(
    parameter int MEM_WORDS = 256
) (
    input  logic     clk,
    input  word_t    i_addr_i,
    output word_t    inst_o,
    input  mem_req_t d_req_i,
    output word_t    d_rdata_o
);

    localparam int AW = $clog2(MEM_WORDS);

    word_t         mem [MEM_WORDS];
    logic [AW-1:0] i_idx;
    logic [AW-1:0] d_idx;

    // word addressed, byte offset dropped
    assign i_idx = i_addr_i[AW+1:2];
    assign d_idx = d_req_i.addr[AW+1:2];

    assign inst_o    = mem[i_idx];
    assign d_rdata_o = mem[d_idx]; // same-cycle read

    always_ff @(posedge clk) begin
        if (d_req_i.req && d_req_i.we) begin
            mem[d_idx] <= d_req_i.wdata;
        end
    end

endmodule

//--- tests/rv_checker.sv
module rv_checker import rv_pkg::*; (
    input logic     clk,
    input logic     rst_n,
    input logic     exit_i,
    input logic     host_gnt_i,
    input mem_req_t core_req_i
);

    int unsigned err_count = 0; // failures seen so far

    exit_held: assert property (@(posedge clk) disable iff (!rst_n) !$fell(exit_i))
        else begin
            err_count++;
            $error("exit_o fell while out of reset");
        end

    // core always wins the data port
    core_over_host: assert property (@(posedge clk) core_req_i.req |-> !host_gnt_i)
        else begin
            err_count++;
            $error("host granted while the core requests the data port");
        end

    no_store_after_exit: assert property (@(posedge clk) disable iff (!rst_n)
        exit_i |-> !(core_req_i.req && core_req_i.we))
        else begin
            err_count++;
            $error("core wrote memory after exit");
        end

endmodule

bind rv_top rv_checker u_checker (
    .clk        (clk),
    .rst_n      (rst_n),
    .exit_i     (exit_o),
    .host_gnt_i (host_gnt_o),
    .core_req_i (core_req)
);

//--- tests/tb_rv_top.sv
module tb_rv_top import rv_pkg::*; ();

    localparam int CLK_PERIOD = 40;
    localparam int NUM_TESTS  = 5;
    localparam int PROG_LEN   = 16; // default EXIT_PC / 4
    localparam int LOAD_LEN   = 32;

    logic     clk = 1'b0;
    logic     rst_n;
    mem_req_t host_req;
    logic     host_gnt;
    word_t    host_rdata;
    logic     exited;
    integer   seed = 32'h573c;
    string    test_name;

    // reference model state
    word_t mreg [32];
    word_t mmem [word_t];
    word_t prog [$];
    bit    prog_is_mem [$];
    word_t chk_addr [$];
    word_t pre_addr [$];
    word_t pre_data [$];

    rv_top u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .host_req_i   (host_req),
        .host_gnt_o   (host_gnt),
        .host_rdata_o (host_rdata),
        .exit_o       (exited)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(NUM_TESTS * (PROG_LEN + LOAD_LEN + 40) * CLK_PERIOD);
        $display("timeout: the tests did not finish in the expected time");
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    task automatic check_word(input string what, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("FAILED %s %s: expected %h actual %h", test_name, what, exp, act);
            $display("SOME TESTS FAILED");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED %s %s: expected %b actual %b", test_name, what, exp, act);
            $display("SOME TESTS FAILED");
            $fatal(1, "bit mismatch");
        end
    endtask

    task automatic host_write(input word_t addr, input word_t data);
        @(posedge clk);
        #2;
        host_req = '{req: 1'b1, we: 1'b1, addr: addr, wdata: data};
        @(negedge clk);
        check_bit("write grant", 1'b1, host_gnt);
    endtask

    task automatic host_read(input word_t addr, output word_t data);
        @(posedge clk);
        #2;
        host_req = '{req: 1'b1, we: 1'b0, addr: addr, wdata: '0};
        @(negedge clk);
        check_bit("read grant", 1'b1, host_gnt);
        data = host_rdata; // same cycle
    endtask

    task automatic host_idle();
        @(posedge clk);
        #2;
        host_req = '0;
    endtask

    function automatic word_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic word_t alu_ref(input logic [2:0] f3, input logic sub,
                                      input word_t a, input word_t b);
        case (f3)
            F3_XOR:  return a ^ b;
            F3_OR:   return a | b;
            F3_AND:  return a & b;
            default: return sub ? a - b : a + b;
        endcase
    endfunction

    function automatic void put(input word_t inst, input bit is_mem,
                                input reg_addr_t rd, input word_t val);
        prog.push_back(inst);
        prog_is_mem.push_back(is_mem);
        if (rd != '0) begin
            mreg[rd] = val;
        end
    endfunction

    function automatic void emit_op(input logic [6:0] f7, input logic [2:0] f3,
                                    input reg_addr_t rd, input reg_addr_t rs1,
                                    input reg_addr_t rs2);
        put({f7, rs2, rs1, f3, rd, OPC_OP}, 1'b0, rd,
            alu_ref(f3, f7 == F7_SUB, mreg[rs1], mreg[rs2]));
    endfunction

    function automatic void emit_imm(input logic [2:0] f3, input reg_addr_t rd,
                                     input reg_addr_t rs1, input logic [11:0] imm);
        put({imm, rs1, f3, rd, OPC_OP_IMM}, 1'b0, rd, alu_ref(f3, 1'b0, mreg[rs1], sext12(imm)));
    endfunction

    function automatic void emit_lw(input reg_addr_t rd, input reg_addr_t rs1,
                                    input logic [11:0] imm);
        put({imm, rs1, F3_LW, rd, OPC_LOAD}, 1'b1, rd, mmem[mreg[rs1] + sext12(imm)]);
    endfunction

    function automatic void emit_sw(input reg_addr_t rs2, input reg_addr_t rs1,
                                    input logic [11:0] imm);
        word_t a;
        a = mreg[rs1] + sext12(imm);
        mmem[a] = mreg[rs2];
        chk_addr.push_back(a);
        put({imm[11:5], rs2, rs1, F3_SW, imm[4:0], OPC_STORE}, 1'b1, '0, '0);
    endfunction

    function automatic void preload(input word_t addr, input word_t data);
        mmem[addr] = data;
        pre_addr.push_back(addr);
        pre_data.push_back(data);
    endfunction

    task automatic new_program(input string name);
        test_name = name;
        foreach (mreg[k]) begin
            mreg[k] = '0;
        end
        mmem.delete();
        prog.delete();
        prog_is_mem.delete();
        chk_addr.delete();
        pre_addr.delete();
        pre_data.delete();
    endtask

    // everything goes in while the core sits in reset
    task automatic load_program();
        while (prog.size() < PROG_LEN) begin
            emit_imm(F3_ADD, 5'd0, 5'd0, 12'h000); // nop padding
        end
        @(posedge clk);
        #2;
        rst_n = 1'b0;
        foreach (prog[k]) begin
            host_write(word_t'(4 * k), prog[k]);
        end
        foreach (pre_addr[k]) begin
            host_write(pre_addr[k], pre_data[k]);
        end
        host_idle();
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
    endtask

    task automatic run_program();
        word_t edges;
        edges = '0;
        while (exited !== 1'b1) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
        end
        check_word("edges to exit", PROG_LEN, edges);
    endtask

    task automatic check_results();
        word_t got;
        foreach (chk_addr[k]) begin
            host_read(chk_addr[k], got);
            check_word($sformatf("mem[%h]", chk_addr[k]), mmem[chk_addr[k]], got);
        end
        host_idle();
    endtask

    task automatic test_host_port();
        word_t written [word_t];
        word_t a;
        word_t d;
        test_name = "test_host_port";
        @(posedge clk);
        #2;
        rst_n = 1'b0;
        repeat (8) begin
            a = $random(seed) & 32'h0000_03fc;
            d = $random(seed);
            written[a] = d;
            host_write(a, d);
        end
        foreach (written[k]) begin
            host_read(k, d);
            check_word("readback", written[k], d);
        end
        host_idle();
    endtask

    task automatic test_r_type();
        new_program("test_r_type");
        emit_imm(F3_ADD, 5'd1, 5'd0, 12'($random(seed)));
        emit_imm(F3_ADD, 5'd2, 5'd0, 12'($random(seed)));
        emit_op(F7_ADD, F3_ADD, 5'd6, 5'd1, 5'd2);
        emit_op(F7_SUB, F3_ADD, 5'd7, 5'd1, 5'd2);
        emit_op(F7_ADD, F3_AND, 5'd8, 5'd1, 5'd2);
        emit_op(F7_ADD, F3_OR, 5'd9, 5'd1, 5'd2);
        emit_op(F7_ADD, F3_XOR, 5'd10, 5'd1, 5'd2);
        for (int r = 6; r <= 10; r++) begin
            emit_sw(reg_addr_t'(r), 5'd0, 12'(256 + 4 * (r - 6)));
        end
        load_program();
        run_program();
        check_results();
    endtask

    task automatic test_i_type();
        new_program("test_i_type");
        for (int a = 'h140; a < 'h154; a += 4) begin
            preload(word_t'(a), 32'hdead_beef); // stale data the stores must replace
        end
        emit_imm(F3_ADD, 5'd1, 5'd0, 12'($random(seed)));
        emit_imm(F3_AND, 5'd2, 5'd1, 12'($random(seed)) | 12'h800);
        emit_imm(F3_OR, 5'd3, 5'd1, 12'($random(seed)) | 12'h800);
        emit_imm(F3_XOR, 5'd4, 5'd1, 12'($random(seed)) | 12'h800);
        emit_imm(F3_ADD, 5'd0, 5'd1, 12'h7ff);
        emit_imm(F3_ADD, 5'd5, 5'd0, 12'h123);
        put({12'h0ff, 5'd1, 3'b000, 5'd5, 7'b1111111}, 1'b0, '0, '0); // unknown opcode
        put({7'b0000001, 5'd1, 5'd1, F3_ADD, 5'd5, OPC_OP}, 1'b0, '0, '0); // mul
        emit_sw(5'd2, 5'd0, 12'h140);
        emit_sw(5'd3, 5'd0, 12'h144);
        emit_sw(5'd4, 5'd0, 12'h148);
        emit_sw(5'd0, 5'd0, 12'h14c);
        emit_sw(5'd5, 5'd0, 12'h150);
        load_program();
        run_program();
        check_results();
    endtask

    task automatic test_load_store();
        new_program("test_load_store");
        for (int a = 'h180; a < 'h1a0; a += 8) begin
            preload(word_t'(a), $random(seed));
        end
        emit_imm(F3_ADD, 5'd1, 5'd0, 12'h190);
        emit_lw(5'd2, 5'd1, 12'hff0); // -16
        emit_lw(5'd3, 5'd1, 12'hff8);
        emit_lw(5'd4, 5'd1, 12'h000);
        emit_lw(5'd5, 5'd1, 12'h008);
        emit_op(F7_ADD, F3_ADD, 5'd6, 5'd2, 5'd3);
        emit_op(F7_ADD, F3_ADD, 5'd7, 5'd4, 5'd5);
        emit_op(F7_ADD, F3_ADD, 5'd8, 5'd6, 5'd7);
        emit_sw(5'd6, 5'd1, 12'hffc);
        emit_sw(5'd7, 5'd1, 12'h014);
        emit_sw(5'd8, 5'd0, 12'h1a8);
        load_program();
        run_program();
        check_results();
    endtask

    task automatic test_arbitration_exit();
        word_t d;
        word_t got;
        new_program("test_arbitration_exit");
        preload(32'h1c0, $random(seed));
        preload(32'h1c4, $random(seed));
        emit_imm(F3_ADD, 5'd1, 5'd0, 12'h1c0);
        emit_lw(5'd2, 5'd1, 12'h000);
        emit_imm(F3_ADD, 5'd3, 5'd2, 12'($random(seed)));
        emit_lw(5'd4, 5'd1, 12'h004);
        emit_op(F7_ADD, F3_XOR, 5'd5, 5'd3, 5'd4);
        emit_sw(5'd5, 5'd1, 12'h008);
        emit_op(F7_ADD, F3_OR, 5'd6, 5'd5, 5'd2);
        emit_lw(5'd7, 5'd1, 12'h008); // reads back the earlier store
        emit_op(F7_SUB, F3_ADD, 5'd8, 5'd7, 5'd6);
        emit_sw(5'd8, 5'd1, 12'h00c);
        // a store parked at the exit pc must never fire
        preload(word_t'(4 * PROG_LEN), {7'h00, 5'd1, 5'd1, F3_SW, 5'h10, OPC_STORE});
        preload(32'h1d0, 32'hdead_beef);
        chk_addr.push_back(32'h1d0);
        load_program();
        host_req = '{req: 1'b1, we: 1'b0, addr: 32'h200, wdata: '0}; // host polls every cycle
        for (int k = 0; k < PROG_LEN; k++) begin
            @(negedge clk);
            check_bit("exit before end", 1'b0, exited);
            check_bit($sformatf("grant at pc %0h", 4 * k), !prog_is_mem[k], host_gnt);
            @(posedge clk);
        end
        @(negedge clk);
        check_bit("exit after N edges", 1'b1, exited);
        d = $random(seed);
        host_write(32'h204, d);
        host_read(32'h204, got);
        check_word("host access after exit", d, got);
        check_results();
    endtask

    initial begin
        rst_n    = 1'b0;
        host_req = '0;
        test_host_port();
        test_r_type();
        test_i_type();
        test_load_store();
        test_arbitration_exit();
        if (u_dut.u_checker.err_count != 0) begin
            $display("the bound checker saw %0d assertion failures", u_dut.u_checker.err_count);
            $display("SOME TESTS FAILED");
            $fatal(1, "assertion failures");
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule
